// File: hw/ddr_ctrl_pkg.sv
`default_nettype none

package ddr_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    typedef logic [14:0] row_addr_t;    // A14..A0 during ACT
    typedef logic [9:0]  col_addr_t;    // A9..A0 during RD/WR
    typedef logic [2:0]  bank_t;        // BA2..BA0
    typedef logic [7:0]  dq_t;          // One lower byte lane beat
    typedef logic [14:0] mem_addr_t;    // Address pins

    localparam int BURST_BEATS = 4;     // Beats per access

    // Beat 0 sits in the low byte
    typedef logic [BURST_BEATS*$bits(dq_t)-1:0] burst_data_t;

    ////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        RESET_WAIT,     // Memory reset pin held low
        INIT_WAIT,      // Waiting on ZQ strobe
        ZQ_CAL,
        IDLE,
        REFRESH,        // REF issued here
        REFRESH_WAIT,   // tRFC
        ACTIVATE,       // ACT issued here
        BANK_ACTIVE,    // tRCD
        COLUMN,         // WR or RD issued here
        LATENCY_WAIT,   // WL / RL minus preamble
        BURST,          // Preamble then data beats
        PRECHARGE       // PRE issued here
    } seq_state_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP = 4'b0111,
        CMD_REF = 4'b0001,
        CMD_ACT = 4'b0011,
        CMD_WR  = 4'b0100,
        CMD_RD  = 4'b0101,
        CMD_PRE = 4'b0010
    } mem_cmd_t;

    // Fixed column command bits
    localparam logic A10_AP  = 1'b0;    // No auto precharge
    localparam logic A12_BL8 = 1'b1;    // BL8 on the fly encoding

endpackage

`default_nettype wire

// File: hw/ddr_seq_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_seq_fsm import ddr_ctrl_pkg::*; #(
    parameter int RESET_CYCLES = 10,
    parameter int T_RFC        = 103,
    parameter int T_RCD        = 10,
    parameter int WL           = 7,
    parameter int RL           = 5
) (
    input  wire logic        CLK,
    input  wire logic        rst_n,
    input  wire logic        zqcl,
    input  wire logic        refresh_req,
    input  wire logic        write_req,
    input  wire logic        read_req,
    input  wire row_addr_t   row_addr,
    input  wire col_addr_t   col_addr,
    input  wire bank_t       bank_addr,
    input  wire burst_data_t wr_data,
    output seq_state_t       state,
    output mem_cmd_t         cmd,
    output logic             is_write,
    output row_addr_t        row,
    output col_addr_t        col,
    output bank_t            bank,
    output burst_data_t      wr_word,
    output logic             idle
);

    localparam int TMR_W = 16;  // Covers tRFC with room

    logic [TMR_W-1:0] timer;    // Shared down counter
    logic [TMR_W-1:0] lat_wait; // Cycles between column cmd and preamble
    logic             rw_req;
    logic             accept_rw;

    assign rw_req = write_req | read_req;

    // Column cycle and preamble cycle are part of the latency
    assign lat_wait = is_write ? TMR_W'(WL - 2) : TMR_W'(RL - 2);

    // Sampled only once idle is visible outside
    assign accept_rw = (state == IDLE) && idle && !refresh_req && rw_req;

    ////////////////////////////////////////////////////////////
    // State, timer and command
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RESET_WAIT;
            cmd      <= CMD_NOP;
            timer    <= TMR_W'(RESET_CYCLES - 1);
            is_write <= 1'b0;
            idle     <= 1'b0;
        end else begin
            cmd  <= CMD_NOP;            // Commands last one cycle
            idle <= (state == IDLE);    // Lines up with the pins

            case (state)
                RESET_WAIT: begin
                    if (timer == '0)
                        state <= INIT_WAIT;
                    else
                        timer <= timer - 1'b1;
                end

                INIT_WAIT: begin
                    if (zqcl)
                        state <= ZQ_CAL;
                end

                ZQ_CAL: state <= IDLE;

                IDLE: begin
                    if (idle && refresh_req) begin  // Refresh first
                        state <= REFRESH;
                        cmd   <= CMD_REF;
                    end else if (accept_rw) begin
                        state    <= ACTIVATE;
                        cmd      <= CMD_ACT;
                        is_write <= write_req;      // Write beats read
                    end
                end

                REFRESH: begin
                    state <= REFRESH_WAIT;
                    timer <= TMR_W'(T_RFC - 1);
                end

                REFRESH_WAIT: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (refresh_req) begin // Back to back refresh
                        state <= REFRESH;
                        cmd   <= CMD_REF;
                    end else begin
                        state <= IDLE;
                    end
                end

                ACTIVATE: begin
                    state <= BANK_ACTIVE;
                    timer <= TMR_W'(T_RCD - 1);
                end

                BANK_ACTIVE: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        state <= COLUMN;
                        cmd   <= is_write ? CMD_WR : CMD_RD;
                    end
                end

                COLUMN: begin
                    if (lat_wait == '0) begin       // Latency of two
                        state <= BURST;
                        timer <= TMR_W'(BURST_BEATS);
                    end else begin
                        state <= LATENCY_WAIT;
                        timer <= lat_wait - 1'b1;
                    end
                end

                LATENCY_WAIT: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        state <= BURST;
                        timer <= TMR_W'(BURST_BEATS);   // Preamble plus beats
                    end
                end

                BURST: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        state <= PRECHARGE;
                        cmd   <= CMD_PRE;
                    end
                end

                PRECHARGE: state <= IDLE;

                default: state <= RESET_WAIT;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Request payload
    ////////////////////////////////////////////////////////////

    // Held until the next accepted access
    always_ff @(posedge CLK) begin
        if (accept_rw) begin
            row     <= row_addr;
            col     <= col_addr;
            bank    <= bank_addr;
            wr_word <= wr_data;     // Taken even for reads
        end
    end

endmodule

`default_nettype wire

// File: hw/ddr_cmd_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_cmd_encoder import ddr_ctrl_pkg::*; (
    input  wire logic       CLK,
    input  wire logic       rst_n,
    input  wire seq_state_t state,
    input  wire mem_cmd_t   cmd,
    input  wire row_addr_t  row,
    input  wire col_addr_t  col,
    input  wire bank_t      bank,
    input  wire logic       is_write,
    output logic            cs_n,
    output logic            ras_n,
    output logic            cas_n,
    output logic            we_n,
    output mem_addr_t       addr,
    output bank_t           ba,
    output logic            dm,
    output logic            ddr_reset_n
);

    mem_addr_t col_word;
    logic      burst_q;     // Previous cycle was BURST
    logic      wr_beat;

    // A14:13 and A11 unused, A10 and A12 fixed
    assign col_word = {2'b00, A12_BL8, 1'b0, A10_AP, col};

    // First BURST cycle is the preamble
    assign wr_beat = is_write && (state == BURST) && burst_q;

    ////////////////////////////////////////////////////////////
    // Pin registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            {cs_n, ras_n, cas_n, we_n} <= CMD_NOP;
            addr        <= '0;
            ba          <= '0;
            dm          <= 1'b1;
            ddr_reset_n <= 1'b0;
            burst_q     <= 1'b0;
        end else begin
            {cs_n, ras_n, cas_n, we_n} <= cmd;
            burst_q     <= (state == BURST);
            dm          <= !wr_beat;                // Mask all but write data
            ddr_reset_n <= (state != RESET_WAIT);

            case (cmd)
                CMD_ACT: begin
                    addr <= row;
                    ba   <= bank;
                end
                CMD_WR, CMD_RD: begin
                    addr <= col_word;
                    ba   <= bank;
                end
                CMD_PRE: begin
                    addr <= '0;     // A10 low so one bank only
                    ba   <= bank;
                end
                default: addr <= '0;    // ba keeps last bank
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/ddr_dq_path.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_dq_path import ddr_ctrl_pkg::*; (
    input  wire logic        CLK,
    input  wire logic        rst_n,
    input  wire seq_state_t  state,
    input  wire logic        is_write,
    input  wire burst_data_t wr_word,
    input  wire dq_t         dq_in,
    output dq_t              dq_out,
    output logic             dq_oe,
    output logic             dqs,
    output logic             dqs_n,
    output burst_data_t      rd_data,
    output logic             rd_valid
);

    localparam int DW     = $bits(dq_t);
    localparam int BW     = $bits(burst_data_t);
    localparam int BEAT_W = $clog2(BURST_BEATS + 1);

    logic [BEAT_W-1:0] beat_cnt;    // 0 is preamble, then beats 1..4
    logic              in_burst;
    logic              data_beat;
    logic              rd_beat_q;   // Pin cycle holds a read beat
    logic              rd_last_q;   // Pin cycle holds the last read beat
    burst_data_t       wr_shift;
    burst_data_t       rd_shift;

    assign in_burst  = (state == BURST);
    assign data_beat = in_burst && (beat_cnt != '0);

    ////////////////////////////////////////////////////////////
    // Strobe and direction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            dqs       <= 1'b1;      // Parked high
            dqs_n     <= 1'b0;
            dq_oe     <= 1'b0;
            rd_beat_q <= 1'b0;
            rd_last_q <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            beat_cnt <= in_burst ? beat_cnt + 1'b1 : '0;

            // Low on preamble then 1 0 1 0
            dqs   <= in_burst ? beat_cnt[0] : 1'b1;
            dqs_n <= in_burst ? !beat_cnt[0] : 1'b0;

            dq_oe     <= is_write && data_beat;
            rd_beat_q <= !is_write && data_beat;
            rd_last_q <= !is_write && in_burst && (beat_cnt == BEAT_W'(BURST_BEATS));
            rd_valid  <= rd_last_q;             // Single pulse
        end
    end

    ////////////////////////////////////////////////////////////
    // Data beats
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        // Load on preamble, low byte goes first
        if (in_burst && (beat_cnt == '0))
            wr_shift <= wr_word;
        else if (data_beat)
            wr_shift <= wr_shift >> DW;
        dq_out <= wr_shift[DW-1:0];

        // Sampled at the end of each pin beat
        if (rd_beat_q)
            rd_shift <= {dq_in, rd_shift[BW-1:DW]};
        if (rd_last_q)
            rd_data <= {dq_in, rd_shift[BW-1:DW]};  // Fourth beat lands on top
    end

endmodule

`default_nettype wire

// File: hw/ddr_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_ctrl_top import ddr_ctrl_pkg::*; #(
    parameter int RESET_CYCLES = 10,
    parameter int T_RFC        = 103,
    parameter int T_RCD        = 10,
    parameter int WL           = 7,
    parameter int RL           = 5
) (
    input  wire logic        CLK,
    input  wire logic        rst_n,
    input  wire logic        zqcl,
    input  wire logic        refresh_req,
    input  wire logic        write_req,
    input  wire logic        read_req,
    input  wire row_addr_t   row_addr,
    input  wire col_addr_t   col_addr,
    input  wire bank_t       bank_addr,
    input  wire burst_data_t wr_data,
    output wire logic        idle,
    output wire burst_data_t rd_data,
    output wire logic        rd_valid,
    output wire logic        cs_n,
    output wire logic        ras_n,
    output wire logic        cas_n,
    output wire logic        we_n,
    output wire mem_addr_t   addr,
    output wire bank_t       ba,
    output wire logic        dm,
    output wire logic        dqs,
    output wire logic        dqs_n,
    output wire logic        ddr_reset_n,
    inout  wire dq_t         dq
);

    seq_state_t  state;
    mem_cmd_t    cmd;
    logic        is_write;
    row_addr_t   row;
    col_addr_t   col;
    bank_t       bank;
    burst_data_t wr_word;
    dq_t         dq_out;
    logic        dq_oe;

    // Lower byte lane, released outside write beats
    assign dq = dq_oe ? dq_out : 'z;

    ddr_seq_fsm #(
        .RESET_CYCLES (RESET_CYCLES),
        .T_RFC        (T_RFC),
        .T_RCD        (T_RCD),
        .WL           (WL),
        .RL           (RL)
    ) i_seq (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .zqcl        (zqcl),
        .refresh_req (refresh_req),
        .write_req   (write_req),
        .read_req    (read_req),
        .row_addr    (row_addr),
        .col_addr    (col_addr),
        .bank_addr   (bank_addr),
        .wr_data     (wr_data),
        .state       (state),
        .cmd         (cmd),
        .is_write    (is_write),
        .row         (row),
        .col         (col),
        .bank        (bank),
        .wr_word     (wr_word),
        .idle        (idle)
    );

    ddr_cmd_encoder i_enc (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .state       (state),
        .cmd         (cmd),
        .row         (row),
        .col         (col),
        .bank        (bank),
        .is_write    (is_write),
        .cs_n        (cs_n),
        .ras_n       (ras_n),
        .cas_n       (cas_n),
        .we_n        (we_n),
        .addr        (addr),
        .ba          (ba),
        .dm          (dm),
        .ddr_reset_n (ddr_reset_n)
    );

    ddr_dq_path i_dq (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .state    (state),
        .is_write (is_write),
        .wr_word  (wr_word),
        .dq_in    (dq),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dqs      (dqs),
        .dqs_n    (dqs_n),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,  // 8 ns clock
    parameter int RESET_LEN   = 8   // Cycles with rst_n low
) (
    output logic CLK,
    output logic rst_n
);

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // Release on a falling edge like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_LEN) @(posedge CLK);
        @(negedge CLK);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/ddr_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ddr_ctrl_tb;

    localparam int RESET_CYCLES = 10;
    localparam int T_RFC        = 103;
    localparam int T_RCD        = 10;
    localparam int WL           = 7;
    localparam int RL           = 5;
    localparam int WAIT_LIMIT   = 1000;         // Cycles before a wait gives up
    localparam logic [31:0] LFSR_SEED = 32'h06186502;

    // DDR3 truth table in {cs_n, ras_n, cas_n, we_n} order
    localparam logic [3:0] CMD_NOP = 4'b0111;
    localparam logic [3:0] CMD_REF = 4'b0001;
    localparam logic [3:0] CMD_ACT = 4'b0011;
    localparam logic [3:0] CMD_WR  = 4'b0100;
    localparam logic [3:0] CMD_RD  = 4'b0101;
    localparam logic [3:0] CMD_PRE = 4'b0010;

    wire         CLK;
    wire         rst_n;
    logic        zqcl;
    logic        refresh_req;
    logic        write_req;
    logic        read_req;
    logic [14:0] row_addr;
    logic [9:0]  col_addr;
    logic [2:0]  bank_addr;
    logic [31:0] wr_data;
    wire         idle;
    wire         rd_valid;
    wire         cs_n;
    wire         ras_n;
    wire         cas_n;
    wire         we_n;
    wire [31:0]  rd_data;
    wire [14:0]  addr;
    wire [2:0]   ba;
    wire         dm;
    wire         dqs;
    wire         dqs_n;
    wire         ddr_reset_n;
    wire [7:0]   dq;
    wire [3:0]   pin_cmd;
    logic        dq_en;                         // Memory model drives DQ
    logic [7:0]  dq_drv;
    logic [31:0] lfsr_state;
    int          chk_cnt;
    int          err_cnt;
    int          tmo_cnt;

    assign pin_cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq      = dq_en ? dq_drv : 8'hzz;    // Released outside read beats

    tb_clock_gen i_clk (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    ddr_ctrl_top #(
        .RESET_CYCLES (RESET_CYCLES),
        .T_RFC        (T_RFC),
        .T_RCD        (T_RCD),
        .WL           (WL),
        .RL           (RL)
    ) i_dut (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .zqcl        (zqcl),
        .refresh_req (refresh_req),
        .write_req   (write_req),
        .read_req    (read_req),
        .row_addr    (row_addr),
        .col_addr    (col_addr),
        .bank_addr   (bank_addr),
        .wr_data     (wr_data),
        .idle        (idle),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .cs_n        (cs_n),
        .ras_n       (ras_n),
        .cas_n       (cas_n),
        .we_n        (we_n),
        .addr        (addr),
        .ba          (ba),
        .dm          (dm),
        .dqs         (dqs),
        .dqs_n       (dqs_n),
        .ddr_reset_n (ddr_reset_n),
        .dq          (dq)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};   // One step per bit
        end
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error: %s = 0x%0h, expected 0x%0h (%0t)", name, actual, expected,
                     $time);
        end
    endtask

    task automatic timed_out(input string what);
        tmo_cnt++;
        $display("Timeout: gave up waiting for %s (%0t)", what, $time);
    endtask

    task automatic step_cycle;
        @(negedge CLK);                     // Pins are stable mid cycle
    endtask

    // Next non NOP pin command and the NOP cycles before it
    task automatic next_command(output logic [3:0] c, output int nops, output bit ok);
        int n;
        n    = 0;
        nops = 0;
        ok   = 1'b0;
        c    = CMD_NOP;
        while (!ok && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
            if (pin_cmd !== CMD_NOP) begin
                c  = pin_cmd;
                ok = 1'b1;
            end else begin
                nops++;
            end
        end
        if (!ok)
            timed_out("the next memory command");
    endtask

    task automatic await_idle(output bit ok);
        int n;
        n = 0;
        while (idle !== 1'b1 && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
        end
        ok = (idle === 1'b1);
        if (!ok)
            timed_out("idle");
    endtask

    // NOP cycles from a REF until idle is back
    task automatic nop_run_until_idle(output int n, output bit ok);
        n = 0;
        step_cycle();
        while (idle !== 1'b1 && n < WAIT_LIMIT) begin
            compare("cmd during tRFC", pin_cmd, CMD_NOP);
            n++;
            step_cycle();
        end
        ok = (idle === 1'b1);
        if (!ok)
            timed_out("idle after refresh");
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic power_up;
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            compare("ddr_reset_n in reset", ddr_reset_n, 1'b0);
            compare("cmd in reset", pin_cmd, CMD_NOP);
            compare("idle in reset", idle, 1'b0);
            compare("rd_valid in reset", rd_valid, 1'b0);
            step_cycle();
            n++;
        end
        if (rst_n !== 1'b1) begin
            timed_out("release of rst_n");
            return;
        end
        n = 0;
        while (ddr_reset_n !== 1'b1 && n < WAIT_LIMIT) begin
            compare("cmd in memory reset", pin_cmd, CMD_NOP);
            compare("idle in memory reset", idle, 1'b0);
            n++;
            step_cycle();
        end
        compare("ddr_reset_n low cycles", n, RESET_CYCLES);
        for (n = 0; n < 5; n++) begin       // Nothing moves before ZQ
            compare("idle before zqcl", idle, 1'b0);
            compare("cmd before zqcl", pin_cmd, CMD_NOP);
            step_cycle();
        end
        zqcl = 1'b1;
        step_cycle();
        zqcl = 1'b0;
        n = 0;
        while (idle !== 1'b1 && n < WAIT_LIMIT) begin
            compare("cmd during ZQ", pin_cmd, CMD_NOP);
            n++;
            step_cycle();
        end
        if (idle !== 1'b1)
            timed_out("idle after zqcl");
        else
            compare("cycles from zqcl to idle", n, 2);
    endtask

    task automatic refresh_sequence(input bit held);
        logic [3:0] c;
        int         nops;
        bit         ok;
        await_idle(ok);
        if (!ok) return;
        refresh_req = 1'b1;
        step_cycle();                       // Accepted at this edge
        if (!held)
            refresh_req = 1'b0;
        next_command(c, nops, ok);
        if (!ok) return;
        compare("cmd on refresh", c, CMD_REF);
        compare("cycles from accept to REF", nops, 0);
        compare("idle at REF", idle, 1'b0);
        if (held) begin
            next_command(c, nops, ok);      // Second REF straight after tRFC
            if (!ok) return;
            compare("cmd after held refresh", c, CMD_REF);
            compare("NOP cycles for tRFC", nops, T_RFC);
            refresh_req = 1'b0;
        end
        nop_run_until_idle(nops, ok);
        if (ok)
            compare("NOP cycles before idle", nops, T_RFC);
    endtask

    // Request already raised or raised here, then one full access
    task automatic access_sequence(input bit wr);
        logic [31:0] rnd;
        logic [14:0] row;
        logic [9:0]  col;
        logic [2:0]  bank;
        logic [31:0] word;                  // Write data or model read data
        logic [3:0]  c;
        int          nops;
        int          lat;
        int          k;
        int          beat;
        bit          ok;
        random_bits(15, rnd);
        row = rnd[14:0];
        random_bits(10, rnd);
        col = rnd[9:0];
        random_bits(3, rnd);
        bank = rnd[2:0];
        random_bits(32, rnd);
        word = rnd;
        lat  = wr ? WL : RL;
        row_addr  = row;
        col_addr  = col;
        bank_addr = bank;
        wr_data   = wr ? word : ~word;      // Reads see a different word here
        if (wr)
            write_req = 1'b1;
        else
            read_req = 1'b1;
        next_command(c, nops, ok);
        if (!ok) return;
        if (wr)
            write_req = 1'b0;
        else
            read_req = 1'b0;
        compare("cmd at ACT", c, CMD_ACT);
        compare("addr at ACT", addr, row);
        compare("ba at ACT", ba, bank);
        compare("idle at ACT", idle, 1'b0);
        next_command(c, nops, ok);
        if (!ok) return;
        compare("cmd at column", c, wr ? CMD_WR : CMD_RD);
        compare("NOP cycles for tRCD", nops, T_RCD);
        compare("addr at column", addr, {2'b00, 1'b1, 1'b0, 1'b0, col}); // A12 high A10 low
        compare("ba at column", ba, bank);
        for (k = 1; k <= lat + 3; k++) begin
            step_cycle();
            beat = k - lat;                 // Preamble at -1
            compare("cmd in latency", pin_cmd, CMD_NOP);
            compare("dm", dm, !(wr && beat >= 0));
            compare("rd_valid in burst", rd_valid, 1'b0);
            if (beat == -1) begin
                compare("dqs preamble", dqs, 1'b0);
                compare("dqs_n preamble", dqs_n, 1'b1);
            end else if (beat >= 0) begin
                compare("dqs", dqs, (beat % 2) == 0);
                compare("dqs_n", dqs_n, (beat % 2) != 0);
                if (wr)
                    compare("dq", dq, word[8*beat +: 8]);
            end
            if (!wr) begin
                compare("dq_oe on read", i_dut.dq_oe, 1'b0);
                if (beat >= 0) begin        // Held until the DUT samples it
                    dq_drv = word[8*beat +: 8];
                    dq_en  = 1'b1;
                end
            end
        end
        next_command(c, nops, ok);
        dq_en = 1'b0;
        if (!ok) return;
        compare("cmd after burst", c, CMD_PRE);
        compare("cycles from last beat to PRE", nops, 0);
        compare("ba at PRE", ba, bank);
        compare("A10 at PRE", addr[10], 1'b0);    // Single bank
        compare("dm at PRE", dm, 1'b1);
        compare("rd_valid at PRE", rd_valid, !wr);
        if (!wr)
            compare("rd_data", rd_data, word);
        step_cycle();
        compare("idle after PRE", idle, 1'b1);
        compare("rd_valid after pulse", rd_valid, 1'b0);
    endtask

    task automatic priority_sequence;
        logic [3:0] c;
        int         nops;
        bit         ok;
        await_idle(ok);
        if (!ok) return;
        refresh_req = 1'b1;
        write_req   = 1'b1;
        read_req    = 1'b1;
        next_command(c, nops, ok);
        if (!ok) return;
        refresh_req = 1'b0;
        compare("first cmd with all requests", c, CMD_REF);
        access_sequence(1'b1);              // Write beats read
        access_sequence(1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main
    ////////////////////////////////////////////////////////////

    initial begin
        int  i;
        bit  ok;
        zqcl        = 1'b0;
        refresh_req = 1'b0;
        write_req   = 1'b0;
        read_req    = 1'b0;
        row_addr    = '0;
        col_addr    = '0;
        bank_addr   = '0;
        wr_data     = '0;
        dq_en       = 1'b0;
        dq_drv      = '0;
        lfsr_state  = LFSR_SEED;
        chk_cnt     = 0;
        err_cnt     = 0;
        tmo_cnt     = 0;
        step_cycle();
        power_up();
        refresh_sequence(1'b0);
        refresh_sequence(1'b1);
        for (i = 0; i < 4; i++) begin       // Write, read, write, read
            await_idle(ok);
            if (ok)
                access_sequence(i % 2 == 0);
        end
        priority_sequence();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", chk_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/ddr_ctrl_pkg.sv
hw/ddr_seq_fsm.sv
hw/ddr_cmd_encoder.sv
hw/ddr_dq_path.sv
hw/ddr_ctrl_top.sv
bench/tb_clock_gen.sv
bench/ddr_ctrl_tb.sv
